/* Bender.yml */
package:
  name: i2c_scan

sources:
  - i2c_scan_pkg.sv
  - i2c_master.sv
  - i2c_probe.sv
  - uart_tx.sv
  - i2c_scan.sv
  - scan_top.sv
  - target: test
    files:
      - i2c_target_model.sv
      - tb_scan_top.sv

/* files.f */
i2c_scan_pkg.sv
i2c_master.sv
i2c_probe.sv
uart_tx.sv
i2c_scan.sv
scan_top.sv
i2c_target_model.sv
tb_scan_top.sv

/* i2c_master.sv */
module i2c_master
    import i2c_scan_pkg::*;
(
    input  logic       clk_g,
    input  logic       rst,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic       cmd_start_i,
    input  logic       cmd_write_i,
    input  logic       cmd_stop_i,
    input  logic [7:0] cmd_data_i,
    output logic       scl_oe_o,
    output logic       sda_oe_o,
    output logic       cmd_done_o,
    output logic       cmd_ack_o
);

    logic [I2C_QCNT_W-1:0] qcnt;      // Quarter divider
    logic [1:0]            phase;
    logic [1:0]            qtr;       // Quarter within current bit
    logic [3:0]            bit_cnt;   // 0..7 data, 8 is ack
    logic [8:0]            shreg;     // Data byte plus released ack slot
    logic                  ack_smp;
    logic                  stall;
    logic                  tick;
    logic                  last_qtr;
    logic [1:0]            new_phase;

    // Target holding SCL low while we have released it
    assign stall    = ~scl_oe_o & ~scl_i;
    assign tick     = (phase != MST_IDLE) && (qcnt == '0) && !stall;
    assign last_qtr = (qtr == 2'd3) && ((phase != MST_WRITE) || (bit_cnt == 4'd8));

    always_comb begin
        if (cmd_start_i)      new_phase = MST_START;
        else if (cmd_write_i) new_phase = MST_WRITE;
        else if (cmd_stop_i)  new_phase = MST_STOP;
        else                  new_phase = MST_IDLE;
    end

    // Line drive per quarter, {scl_oe, sda_oe}
    function automatic logic [1:0] drive_f(input logic [1:0] ph, input logic [1:0] q,
                                           input logic b);
        logic [1:0] oe;
        case (ph)
            MST_START: oe = {q == 2'd3, q != 2'd0};             // SDA falls while SCL high
            MST_WRITE: oe = {(q == 2'd0) || (q == 2'd3), ~b};   // SCL high in q1, q2
            MST_STOP:  oe = {q == 2'd0, ~q[1]};                 // SDA rises while SCL high
            default:   oe = 2'b00;
        endcase
        return oe;
    endfunction

    // ======================================================================
    // Phase FSM
    // ======================================================================
    always_ff @(posedge clk_g) begin
        if (rst) begin
            phase      <= MST_IDLE;
            qtr        <= 2'd0;
            bit_cnt    <= 4'd0;
            qcnt       <= '0;
            ack_smp    <= 1'b0;
            scl_oe_o   <= 1'b0;
            sda_oe_o   <= 1'b0;
            cmd_done_o <= 1'b0;
            cmd_ack_o  <= 1'b0;
        end else begin
            cmd_done_o <= 1'b0;
            cmd_ack_o  <= 1'b0;
            if (phase == MST_IDLE) begin
                if (new_phase != MST_IDLE) begin
                    phase   <= new_phase;
                    qtr     <= 2'd0;
                    bit_cnt <= 4'd0;
                    qcnt    <= I2C_QCNT_W'(I2C_QUARTER_DIV - 1);
                    {scl_oe_o, sda_oe_o} <= drive_f(new_phase, 2'd0, cmd_data_i[7]);
                end
            end else if (tick) begin
                qcnt <= I2C_QCNT_W'(I2C_QUARTER_DIV - 1);
                // Mid SCL high on ninth bit
                if ((phase == MST_WRITE) && (qtr == 2'd1) && (bit_cnt == 4'd8)) begin
                    ack_smp <= ~sda_i;
                end
                if (last_qtr) begin
                    phase      <= MST_IDLE;                     // Lines keep q3 drive
                    cmd_done_o <= 1'b1;
                    cmd_ack_o  <= (phase == MST_WRITE) && ack_smp;
                end else if (qtr == 2'd3) begin
                    qtr     <= 2'd0;
                    bit_cnt <= bit_cnt + 4'd1;
                    {scl_oe_o, sda_oe_o} <= drive_f(phase, 2'd0, shreg[7]);
                end else begin
                    qtr <= qtr + 2'd1;
                    {scl_oe_o, sda_oe_o} <= drive_f(phase, qtr + 2'd1, shreg[8]);
                end
            end else if (!stall) begin
                qcnt <= qcnt - 1'b1;
            end
        end
    end

    // Shift register, MSB first, ones fill the ack slot
    always_ff @(posedge clk_g) begin
        if ((phase == MST_IDLE) && cmd_write_i) begin
            shreg <= {cmd_data_i, 1'b1};
        end else if (tick && (qtr == 2'd3)) begin
            shreg <= {shreg[7:0], 1'b1};
        end
    end

    // Done is a single-cycle pulse
    assert property (@(posedge clk_g) disable iff (rst) cmd_done_o |=> !cmd_done_o);

    // Prober never overlaps commands
    assert property (@(posedge clk_g) disable iff (rst)
        $onehot0({cmd_start_i, cmd_write_i, cmd_stop_i}));

endmodule

/* i2c_probe.sv */
module i2c_probe
    import i2c_scan_pkg::*;
(
    input  logic       clk_g,
    input  logic       rst,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic       probe_start_i,
    input  logic [6:0] probe_addr_i,
    output logic       scl_oe_o,
    output logic       sda_oe_o,
    output logic       probe_done_o,
    output logic       probe_found_o
);

    logic [1:0] state;
    logic       cmd_start;
    logic       cmd_write;
    logic       cmd_stop;
    logic [7:0] cmd_data;      // Address byte, R/W = 0
    logic       cmd_done;
    logic       cmd_ack;
    logic       found;

    i2c_master u_master (
        .clk_g       (clk_g),
        .rst         (rst),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .cmd_start_i (cmd_start),
        .cmd_write_i (cmd_write),
        .cmd_stop_i  (cmd_stop),
        .cmd_data_i  (cmd_data),
        .scl_oe_o    (scl_oe_o),
        .sda_oe_o    (sda_oe_o),
        .cmd_done_o  (cmd_done),
        .cmd_ack_o   (cmd_ack)
    );

    // START, address write, STOP; each step waits for done
    always_ff @(posedge clk_g) begin
        if (rst) begin
            state         <= PRB_IDLE;
            cmd_start     <= 1'b0;
            cmd_write     <= 1'b0;
            cmd_stop      <= 1'b0;
            probe_done_o  <= 1'b0;
            probe_found_o <= 1'b0;
        end else begin
            cmd_start     <= 1'b0;                    // Strobes default low
            cmd_write     <= 1'b0;
            cmd_stop      <= 1'b0;
            probe_done_o  <= 1'b0;
            probe_found_o <= 1'b0;
            case (state)
                PRB_IDLE:  if (probe_start_i) begin
                    cmd_start <= 1'b1;
                    state     <= PRB_START;
                end
                PRB_START: if (cmd_done) begin
                    cmd_write <= 1'b1;
                    state     <= PRB_WRITE;
                end
                PRB_WRITE: if (cmd_done) begin
                    cmd_stop <= 1'b1;                 // STOP whether acked or not
                    state    <= PRB_STOP;
                end
                default:   if (cmd_done) begin
                    probe_done_o  <= 1'b1;
                    probe_found_o <= found;
                    state         <= PRB_IDLE;
                end
            endcase
        end
    end

    // Payload, no reset
    always_ff @(posedge clk_g) begin
        if ((state == PRB_IDLE) && probe_start_i) cmd_data <= {probe_addr_i, 1'b0};
        if ((state == PRB_WRITE) && cmd_done)     found    <= cmd_ack;
    end

    // Scanner waits for probe_done before the next address
    assert property (@(posedge clk_g) disable iff (rst) probe_start_i |-> state == PRB_IDLE);

endmodule

/* i2c_scan.sv */
module i2c_scan
    import i2c_scan_pkg::*;
(
    input  logic clk_g,
    input  logic rst,
    input  logic start_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_oe_o,
    output logic sda_oe_o,
    output logic tx_o,
    output logic busy_o
);

    logic [2:0] state;
    logic [6:0] addr;           // Address under probe
    logic       last_addr;
    logic       probe_start;
    logic       probe_done;
    logic       probe_found;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready;
    logic       emit;           // State wants to send a byte

    i2c_probe u_probe (
        .clk_g         (clk_g),
        .rst           (rst),
        .scl_i         (scl_i),
        .sda_i         (sda_i),
        .probe_start_i (probe_start),
        .probe_addr_i  (addr),
        .scl_oe_o      (scl_oe_o),
        .sda_oe_o      (sda_oe_o),
        .probe_done_o  (probe_done),
        .probe_found_o (probe_found)
    );

    uart_tx u_uart (
        .clk_g      (clk_g),
        .rst        (rst),
        .tx_valid_i (tx_valid),
        .tx_data_i  (tx_data),
        .tx_o       (tx_o),
        .tx_ready_o (tx_ready)
    );

    // Nibble to upper-case ASCII hex
    function automatic logic [7:0] hex_f(input logic [3:0] nib);
        logic [7:0] code;
        if (nib < 4'd10) code = CHAR_DIGIT0 + {4'd0, nib};
        else             code = CHAR_HEX_A + {4'd0, nib} - 8'd10;
        return code;
    endfunction

    assign last_addr   = (addr == SCAN_ADDR_LAST);
    assign probe_start = (state == SCN_PROBE);          // One cycle per address
    assign emit        = (state == SCN_HI) || (state == SCN_LO) || (state == SCN_SP) ||
                         (state == SCN_CR) || (state == SCN_LF);
    assign tx_valid    = emit && tx_ready;              // Stall on back-pressure

    always_comb begin
        case (state)
            SCN_HI:  tx_data = hex_f({1'b0, addr[6:4]});
            SCN_LO:  tx_data = hex_f(addr[3:0]);
            SCN_SP:  tx_data = CHAR_SPACE;
            SCN_CR:  tx_data = CHAR_CR;
            SCN_LF:  tx_data = CHAR_LF;
            default: tx_data = 8'h00;
        endcase
    end

    // ======================================================================
    // Scan sequence
    // ======================================================================
    always_ff @(posedge clk_g) begin
        if (rst) begin
            state  <= SCN_IDLE;
            addr   <= SCAN_ADDR_FIRST;
            busy_o <= 1'b0;
        end else begin
            case (state)
                SCN_IDLE:  if (start_i && !busy_o) begin
                    busy_o <= 1'b1;
                    addr   <= SCAN_ADDR_FIRST;
                    state  <= SCN_PROBE;
                end
                SCN_PROBE: state <= SCN_WAIT;
                SCN_WAIT:  if (probe_done) begin
                    if (probe_found)    state <= SCN_HI;   // Report this address
                    else if (last_addr) state <= SCN_CR;
                    else begin
                        addr  <= addr + 7'd1;
                        state <= SCN_PROBE;
                    end
                end
                SCN_HI:    if (tx_valid) state <= SCN_LO;
                SCN_LO:    if (tx_valid) state <= SCN_SP;
                SCN_SP:    if (tx_valid) begin
                    if (last_addr) state <= SCN_CR;
                    else begin
                        addr  <= addr + 7'd1;
                        state <= SCN_PROBE;
                    end
                end
                SCN_CR:    if (tx_valid) state <= SCN_LF;
                default:   if (tx_valid) begin             // LF accepted, scan over
                    busy_o <= 1'b0;
                    state  <= SCN_IDLE;
                end
            endcase
        end
    end

    // Each accepted byte makes the transmitter busy next cycle
    assert property (@(posedge clk_g) disable iff (rst) tx_valid |=> !tx_ready);

endmodule

/* i2c_scan_pkg.sv */
package i2c_scan_pkg;

    // ======================================================================
    // Dividers and periods, small values for simulation
    // ======================================================================
    localparam int I2C_QUARTER_DIV = 5;                      // Clocks per quarter SCL period
    localparam int I2C_QCNT_W      = $clog2(I2C_QUARTER_DIV);
    localparam int UART_BIT_DIV    = 16;                     // Clocks per UART bit
    localparam int UART_CNT_W      = $clog2(UART_BIT_DIV);
    localparam int TRIG_PERIOD     = 40000;                  // Longer than one full scan
    localparam int TRIG_CNT_W      = $clog2(TRIG_PERIOD);
    localparam int SYNC_STAGES     = 4;                      // Enable synchronizer depth

    // Probed 7-bit address window, reserved ranges skipped
    localparam logic [6:0] SCAN_ADDR_FIRST = 7'h08;
    localparam logic [6:0] SCAN_ADDR_LAST  = 7'h77;

    // Report characters
    localparam logic [7:0] CHAR_SPACE  = 8'h20;
    localparam logic [7:0] CHAR_CR     = 8'h0D;
    localparam logic [7:0] CHAR_LF     = 8'h0A;
    localparam logic [7:0] CHAR_DIGIT0 = 8'h30;              // '0'
    localparam logic [7:0] CHAR_HEX_A  = 8'h41;              // 'A'

    // ======================================================================
    // FSM encodings
    // ======================================================================
    localparam logic [1:0] MST_IDLE  = 2'd0;                 // Bit engine
    localparam logic [1:0] MST_START = 2'd1;
    localparam logic [1:0] MST_WRITE = 2'd2;
    localparam logic [1:0] MST_STOP  = 2'd3;

    localparam logic [1:0] PRB_IDLE  = 2'd0;                 // Prober
    localparam logic [1:0] PRB_START = 2'd1;
    localparam logic [1:0] PRB_WRITE = 2'd2;
    localparam logic [1:0] PRB_STOP  = 2'd3;

    localparam logic [2:0] SCN_IDLE  = 3'd0;                 // Scanner
    localparam logic [2:0] SCN_PROBE = 3'd1;
    localparam logic [2:0] SCN_WAIT  = 3'd2;
    localparam logic [2:0] SCN_HI    = 3'd3;
    localparam logic [2:0] SCN_LO    = 3'd4;
    localparam logic [2:0] SCN_SP    = 3'd5;
    localparam logic [2:0] SCN_CR    = 3'd6;
    localparam logic [2:0] SCN_LF    = 3'd7;

endpackage

/* i2c_target_model.sv */
module i2c_target_model
    import i2c_scan_pkg::*;
(
    input  logic         scl_i,
    input  logic         sda_i,
    input  logic [127:0] ack_set_i,       // One bit per 7-bit address
    input  logic [6:0]   stretch_addr_i,
    input  logic         stretch_en_i,
    output logic         scl_pd_o,        // 1 pulls SCL low
    output logic         sda_pd_o,        // 1 pulls SDA low
    output logic         err_o,           // Sticky frame error
    output int           frame_cnt_o      // Well-formed probe frames seen
);

    timeunit 1ns;
    timeprecision 100ps;

    logic       in_frame;
    int         bit_cnt;                  // SCL rises since START
    logic [7:0] addr_byte;
    logic       acking;

    initial begin
        scl_pd_o    = 1'b0;
        sda_pd_o    = 1'b0;
        err_o       = 1'b0;
        frame_cnt_o = 0;
        in_frame    = 1'b0;
        bit_cnt     = 0;
        addr_byte   = 8'h00;
        acking      = 1'b0;
    end

    // START, no repeated START expected
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            if (in_frame) err_o = 1'b1;
            in_frame = 1'b1;
            bit_cnt  = 0;
        end
    end

    // STOP after 9 bit clocks plus the STOP clock, R/W must be 0
    always @(posedge sda_i) begin
        if ((scl_i === 1'b1) && in_frame) begin
            if ((bit_cnt != 10) || (addr_byte[0] !== 1'b0)) err_o = 1'b1;
            else frame_cnt_o++;
            in_frame = 1'b0;
        end
    end

    always @(posedge scl_i) begin
        if (in_frame) begin
            if (bit_cnt < 8) addr_byte = {addr_byte[6:0], sda_i};   // MSB first
            else if ((bit_cnt == 8) && !acking && (sda_i !== 1'b1)) err_o = 1'b1;
            else if (bit_cnt > 9) err_o = 1'b1;                     // Extra clocks
            bit_cnt++;
        end
    end

    // Ack slot opens on the falling edge after the eighth bit
    always @(negedge scl_i) begin
        if (in_frame && (bit_cnt == 8)) begin
            acking   = ack_set_i[addr_byte[7:1]];
            sda_pd_o = acking;
            if (stretch_en_i && (addr_byte[7:1] == stretch_addr_i)) begin
                scl_pd_o = 1'b1;                                    // Hold SCL low
                #305;
                scl_pd_o = 1'b0;
            end
        end else if (in_frame && (bit_cnt == 9)) begin
            sda_pd_o = 1'b0;                                        // Release after ack
            acking   = 1'b0;
        end
    end

endmodule

/* scan_top.sv */
module scan_top
    import i2c_scan_pkg::*;
(
    input  logic clk_g,
    input  logic rst,
    input  logic scan_en_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_oe_o,
    output logic sda_oe_o,
    output logic tx_o,
    output logic busy_o
);

    logic [SYNC_STAGES-1:0] en_sync;   // Enters at MSB, read at bit 0
    logic [TRIG_CNT_W-1:0]  trig_cnt;
    logic                   trig;

    // ======================================================================
    // Enable synchronizer and trigger generator
    // ======================================================================
    always_ff @(posedge clk_g) begin
        if (rst) en_sync <= '0;
        else     en_sync <= {scan_en_i, en_sync[SYNC_STAGES-1:1]};
    end

    always_ff @(posedge clk_g) begin
        if (rst)       trig_cnt <= TRIG_CNT_W'(TRIG_PERIOD - 1);
        else if (trig) trig_cnt <= TRIG_CNT_W'(TRIG_PERIOD - 1);   // Reload
        else           trig_cnt <= trig_cnt - 1'b1;
    end

    assign trig = (trig_cnt == '0);                                 // One cycle per period

    i2c_scan u_scan (
        .clk_g    (clk_g),
        .rst      (rst),
        .start_i  (trig & en_sync[0]),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .scl_oe_o (scl_oe_o),
        .sda_oe_o (sda_oe_o),
        .tx_o     (tx_o),
        .busy_o   (busy_o)
    );

endmodule

/* tb_scan_top.sv */
module tb_scan_top
    import i2c_scan_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic         clk_g;
    logic         rst;
    logic         scan_en;
    logic         scl;
    logic         sda;
    logic         scl_oe;
    logic         sda_oe;
    logic         tx;
    logic         busy;
    logic         scl_pd;
    logic         sda_pd;
    logic [127:0] ack_set;
    logic [6:0]   stretch_addr;
    logic         stretch_en;
    logic         model_err;
    int           frame_cnt;
    int           cycle_cnt;
    logic [7:0]   rx_q[$];                  // Bytes seen on tx

    // Open-drain bus with pull-ups
    assign scl = ((scl_oe === 1'b1) || scl_pd) ? 1'b0 : 1'b1;
    assign sda = ((sda_oe === 1'b1) || sda_pd) ? 1'b0 : 1'b1;

    scan_top DUT (
        .clk_g     (clk_g),
        .rst       (rst),
        .scan_en_i (scan_en),
        .scl_i     (scl),
        .sda_i     (sda),
        .scl_oe_o  (scl_oe),
        .sda_oe_o  (sda_oe),
        .tx_o      (tx),
        .busy_o    (busy)
    );

    i2c_target_model u_target (
        .scl_i          (scl),
        .sda_i          (sda),
        .ack_set_i      (ack_set),
        .stretch_addr_i (stretch_addr),
        .stretch_en_i   (stretch_en),
        .scl_pd_o       (scl_pd),
        .sda_pd_o       (sda_pd),
        .err_o          (model_err),
        .frame_cnt_o    (frame_cnt)
    );

    initial begin
        clk_g = 1'b0;
        forever #5 clk_g = ~clk_g;
    end

    // ======================================================================
    // Watchdogs and UART capture
    // ======================================================================
    always @(posedge clk_g) begin
        cycle_cnt++;
        if (cycle_cnt >= 8 * TRIG_PERIOD) begin
            $display("Timeout after %0d cycles, a scan never finished", cycle_cnt);
            $display("TEST FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    always @(posedge model_err) begin
        $display("Target model saw a malformed I2C frame at %0t", $time);
        $display("TEST FAIL");
        $fatal(1, "bus protocol error");
    end

    initial begin
        logic [7:0] rx_byte;
        wait (rst === 1'b0);
        forever begin
            @(negedge tx);
            repeat (UART_BIT_DIV / 2) @(posedge clk_g);              // Mid start bit
            for (int i = 0; i < 8; i++) begin
                repeat (UART_BIT_DIV) @(posedge clk_g);
                rx_byte[i] = tx;                                     // LSB first
            end
            repeat (UART_BIT_DIV) @(posedge clk_g);
            check_eq("uart stop bit", 1, tx);
            rx_q.push_back(rx_byte);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ASCII upper-case hex digit
    function automatic logic [7:0] ascii_hex(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    function automatic logic [127:0] random_set(input int count);
        logic [127:0] s;
        s = '0;
        repeat (count) s[int'(SCAN_ADDR_FIRST) + ($urandom % 112)] = 1'b1;
        return s;
    endfunction

    task automatic load_targets(input logic [127:0] set, input logic st_en,
                                input logic [6:0] st_addr);
        @(posedge clk_g);
        ack_set      <= set;
        stretch_en   <= st_en;
        stretch_addr <= st_addr;
    endtask

    // In-range acked addresses ascending, then CR LF
    task automatic compare_report(input string name);
        logic [7:0] exp_q[$];
        exp_q = {};
        for (int a = int'(SCAN_ADDR_FIRST); a <= int'(SCAN_ADDR_LAST); a++) begin
            if (ack_set[a]) begin
                exp_q.push_back(ascii_hex(4'(a >> 4)));
                exp_q.push_back(ascii_hex(4'(a)));
                exp_q.push_back(CHAR_SPACE);
            end
        end
        exp_q.push_back(CHAR_CR);
        exp_q.push_back(CHAR_LF);
        check_eq({name, " report length"}, exp_q.size(), rx_q.size());
        foreach (exp_q[i]) check_eq($sformatf("%s byte %0d", name, i), exp_q[i], rx_q[i]);
    endtask

    task automatic scan_once(input string name, input bit drop_early);
        int frames_before;
        rx_q = {};
        frames_before = frame_cnt;
        @(posedge clk_g);
        scan_en <= 1'b1;
        while (busy !== 1'b1) @(posedge clk_g);                   // Next trigger
        if (drop_early) begin
            repeat (100) @(posedge clk_g);
            scan_en <= 1'b0;                                       // Mid scan
        end
        while (busy !== 1'b0) @(posedge clk_g);
        scan_en <= 1'b0;
        repeat (12 * UART_BIT_DIV) @(posedge clk_g);               // LF still on the wire
        compare_report(name);
        check_eq({name, " frames"}, SCAN_ADDR_LAST - SCAN_ADDR_FIRST + 1,
                 frame_cnt - frames_before);
        check_eq({name, " model error"}, 0, model_err);
    endtask

    // Bus and UART stay idle, busy low
    task automatic idle_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk_g);
            check_eq(name, 4'b0100, {busy, tx, scl_oe, sda_oe});
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        cycle_cnt    = 0;
        rst          = 1'b1;
        scan_en      = 1'b0;
        ack_set      = '0;
        stretch_en   = 1'b0;
        stretch_addr = 7'h00;
        void'($urandom(32'h921));
        repeat (3) @(posedge clk_g);
        rst <= 1'b0;

        idle_quiet("disabled_idle", TRIG_PERIOD + 20);

        load_targets(random_set(3 + ($urandom % 4)), 1'b0, 7'h00);
        scan_once("random_targets", 1'b0);

        load_targets((128'd1 << 7'h03) | (128'd1 << 7'h78), 1'b0, 7'h00);   // Out of range only
        scan_once("empty_bus", 1'b0);

        load_targets((128'd1 << 7'h3C) | (128'd1 << 7'h3D), 1'b1, 7'h3C);
        scan_once("clock_stretch", 1'b0);

        load_targets((128'd1 << 7'h08) | (128'd1 << 7'h50) | (128'd1 << 7'h77), 1'b0, 7'h00);
        scan_once("frame_count", 1'b0);

        load_targets((128'd1 << 7'h20) | (128'd1 << 7'h21), 1'b0, 7'h00);
        scan_once("enable_drop", 1'b1);
        idle_quiet("enable_drop idle", TRIG_PERIOD);

        $display("TEST PASS");
        $finish;
    end

endmodule

/* uart_tx.sv */
module uart_tx
    import i2c_scan_pkg::*;
(
    input  logic       clk_g,
    input  logic       rst,
    input  logic       tx_valid_i,
    input  logic [7:0] tx_data_i,
    output logic       tx_o,
    output logic       tx_ready_o
);

    logic [UART_CNT_W-1:0] bcnt;       // Bit time
    logic [3:0]            bits_left;  // Start, 8 data, stop
    logic [9:0]            shreg;

    assign tx_o = shreg[0];            // Idle line reads 1

    always_ff @(posedge clk_g) begin
        if (rst) begin
            shreg      <= '1;
            bcnt       <= '0;
            bits_left  <= 4'd0;
            tx_ready_o <= 1'b1;
        end else if (tx_ready_o) begin
            if (tx_valid_i) begin
                shreg      <= {1'b1, tx_data_i, 1'b0};   // Stop, data LSB first, start
                bcnt       <= UART_CNT_W'(UART_BIT_DIV - 1);
                bits_left  <= 4'd10;
                tx_ready_o <= 1'b0;
            end
        end else if (bcnt == '0) begin
            // End of one bit time
            shreg     <= {1'b1, shreg[9:1]};
            bcnt      <= UART_CNT_W'(UART_BIT_DIV - 1);
            bits_left <= bits_left - 4'd1;
            if (bits_left == 4'd1) begin
                tx_ready_o <= 1'b1;                      // Stop bit done
            end
        end else begin
            bcnt <= bcnt - 1'b1;
        end
    end

endmodule
